// File: verilog/dbg_settings.svh
// UART debug target settings

`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

//////////////////////////////////////////////////
// UART line format
//////////////////////////////////////////////////

// Clock cycles per UART bit
`define DBG_CLKS_PER_BIT 16

// 1 appends an even parity bit after the data bits
`define DBG_PARITY_EN 1

//////////////////////////////////////////////////
// Target memory
//////////////////////////////////////////////////

// Byte address width, 256 bytes
`define DBG_MEM_AW 8

//////////////////////////////////////////////////
// Protocol bytes
//////////////////////////////////////////////////

`define DBG_CMD_READ  8'h11
`define DBG_CMD_WRITE 8'h12
`define DBG_CMD_EXEC  8'h13

`define DBG_BYTE_ACK  8'h06
`define DBG_BYTE_EOT  8'h04

`endif

// File: verilog/dbg_pkg.sv
// Debug protocol types

package dbg_pkg;

  //////////////////////////////////////////////////
  // Data
  //////////////////////////////////////////////////

  // One byte on the UART line
  typedef logic [7:0] dbg_byte_t;

  //////////////////////////////////////////////////
  // Server sequencing
  //////////////////////////////////////////////////

  // Command parsing, then reply and data phases
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    GET_ADDR = 3'd1,
    GET_LEN  = 3'd2,
    SEND_ACK = 3'd3,
    RD_DATA  = 3'd4,
    WR_DATA  = 3'd5,
    SEND_EOT = 3'd6
  } dbg_state_e;

  // READ and WRITE both use GET_LEN,
  // EXEC goes straight from GET_ADDR to SEND_ACK

endpackage

// File: verilog/uart_rx.sv
// UART receiver

`timescale 1ns/1ps
`include "dbg_settings.svh"

module uart_rx (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               rxd_i,
  output dbg_pkg::dbg_byte_t rx_data_o,
  output logic               rx_valid_o,
  output logic               rx_perr_o
);

  localparam int CntW = $clog2(`DBG_CLKS_PER_BIT);
  localparam logic [CntW-1:0] HalfBit = CntW'(`DBG_CLKS_PER_BIT / 2 - 1);
  localparam logic [CntW-1:0] FullBit = CntW'(`DBG_CLKS_PER_BIT - 1);

  localparam logic [2:0] RxIdle   = 3'd0;
  localparam logic [2:0] RxStart  = 3'd1;
  localparam logic [2:0] RxData   = 3'd2;
  localparam logic [2:0] RxParity = 3'd3;
  localparam logic [2:0] RxStop   = 3'd4;

  logic [2:0]         sync_q;
  logic               rxd_s;
  logic               fall;
  logic [2:0]         state_q;
  logic [CntW-1:0]    cnt_q;
  logic [2:0]         bit_q;
  logic               sample;
  logic               par_q;
  logic               par_bad;
  dbg_pkg::dbg_byte_t data_q;

  // Two sync flops, third flop keeps the previous level for edge detect
  assign rxd_s = sync_q[1];
  assign fall  = sync_q[2] & ~sync_q[1];

  // Half a bit after the start edge, then one full bit per sample
  assign sample  = (state_q == RxStart) ? (cnt_q == HalfBit) : (cnt_q == FullBit);
  assign par_bad = (`DBG_PARITY_EN != 0) && (par_q != ^data_q);

  assign rx_data_o = data_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q     <= 3'b111;
      state_q    <= RxIdle;
      cnt_q      <= '0;
      bit_q      <= '0;
      rx_valid_o <= 1'b0;
      rx_perr_o  <= 1'b0;
    end else begin
      sync_q     <= {sync_q[1:0], rxd_i};
      rx_valid_o <= 1'b0;
      rx_perr_o  <= 1'b0;
      cnt_q      <= (state_q == RxIdle || sample) ? '0 : cnt_q + 1'b1;
      case (state_q)
        RxIdle: if (fall) state_q <= RxStart;
        // Glitch shorter than half a bit goes back to idle
        RxStart: if (sample) begin
          state_q <= rxd_s ? RxIdle : RxData;
          bit_q   <= '0;
        end
        RxData: if (sample) begin
          bit_q <= bit_q + 3'd1;
          if (bit_q == 3'd7) state_q <= (`DBG_PARITY_EN != 0) ? RxParity : RxStop;
        end
        RxParity: if (sample) state_q <= RxStop;
        RxStop: if (sample) begin
          state_q    <= RxIdle;
          rx_valid_o <= !par_bad;
          rx_perr_o  <= par_bad;
        end
        default: state_q <= RxIdle;
      endcase
    end
  end

  // Data shifts in LSB first
  always_ff @(posedge clk) begin
    if (sample && state_q == RxData) data_q <= {rxd_s, data_q[7:1]};
    if (sample && state_q == RxParity) par_q <= rxd_s;
  end

endmodule

// File: verilog/uart_tx.sv
// UART transmitter

`timescale 1ns/1ps
`include "dbg_settings.svh"

module uart_tx (
  input  logic               clk,
  input  logic               arst_n_i,
  input  dbg_pkg::dbg_byte_t tx_data_i,
  input  logic               tx_start_i,
  output logic               txd_o,
  output logic               tx_busy_o
);

  localparam int NumBits = 10 + `DBG_PARITY_EN;
  localparam int CntW    = $clog2(`DBG_CLKS_PER_BIT);
  localparam logic [CntW-1:0] FullBit = CntW'(`DBG_CLKS_PER_BIT - 1);

  logic            busy_q;
  logic [CntW-1:0] cnt_q;
  logic [3:0]      bit_q;
  logic            bit_end;
  logic [10:0]     frame;
  logic [10:0]     shift_q;

  // Stop, parity, data, start from MSB down to LSB
  always_comb begin
    if (`DBG_PARITY_EN != 0) begin
      frame = {1'b1, ^tx_data_i, tx_data_i, 1'b0};
    end else begin
      frame = {2'b11, tx_data_i, 1'b0};
    end
  end

  assign bit_end   = (cnt_q == FullBit);
  assign txd_o     = busy_q ? shift_q[0] : 1'b1;
  assign tx_busy_o = busy_q;

  //////////////////////////////////////////////////
  // Bit timing
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      bit_q  <= '0;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
        bit_q  <= '0;
      end
    end else if (bit_end) begin
      cnt_q <= '0;
      bit_q <= bit_q + 4'd1;
      // Busy drops at the end of the stop bit
      if (bit_q == 4'(NumBits - 1)) busy_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Frame shifter, ones fill in behind
  always_ff @(posedge clk) begin
    if (!busy_q && tx_start_i) begin
      shift_q <= frame;
    end else if (busy_q && bit_end) begin
      shift_q <= {1'b1, shift_q[10:1]};
    end
  end

endmodule

// File: verilog/dbg_server.sv
// Debug protocol server

`timescale 1ns/1ps
`include "dbg_settings.svh"

module dbg_server (
  input  logic               clk,
  input  logic               arst_n_i,
  input  dbg_pkg::dbg_byte_t rx_data_i,
  input  logic               rx_valid_i,
  input  logic               tx_busy_i,
  output dbg_pkg::dbg_byte_t tx_data_o,
  output logic               tx_start_o,
  output logic               exec_o,
  output logic [63:0]        exec_addr_o
);

  localparam int MemDepth = 1 << `DBG_MEM_AW;

  dbg_pkg::dbg_state_e    state_q;
  dbg_pkg::dbg_byte_t     cmd_q;
  logic [2:0]             byte_cnt_q;
  logic [63:0]            addr_q;
  logic [15:0]            len_q;
  logic [15:0]            off_q;
  logic                   tx_busy_q;
  logic                   tx_ready;
  logic                   last_byte;
  logic                   last_data;
  logic                   len_zero;
  logic [`DBG_MEM_AW-1:0] mem_idx;
  logic                   mem_we;
  dbg_pkg::dbg_byte_t     mem_q [MemDepth];
  dbg_pkg::dbg_byte_t     rd_data_q;

  //////////////////////////////////////////////////
  // Status decode
  //////////////////////////////////////////////////

  // Transmitter idle for at least one cycle and no start in flight
  assign tx_ready = !tx_busy_i && !tx_busy_q && !tx_start_o;

  assign last_byte = (byte_cnt_q == 3'd7);
  assign last_data = ((off_q + 16'd1) == len_q);
  assign len_zero  = (len_q == 16'd0);

  // Index wraps around the memory size
  assign mem_idx = addr_q[`DBG_MEM_AW-1:0] + off_q[`DBG_MEM_AW-1:0];
  assign mem_we  = (state_q == dbg_pkg::WR_DATA) && rx_valid_i;

  assign exec_addr_o = addr_q;

  //////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= dbg_pkg::IDLE;
      cmd_q      <= '0;
      byte_cnt_q <= '0;
      len_q      <= '0;
      off_q      <= '0;
      tx_busy_q  <= 1'b0;
      tx_start_o <= 1'b0;
      exec_o     <= 1'b0;
    end else begin
      tx_busy_q  <= tx_busy_i;
      tx_start_o <= 1'b0;
      exec_o     <= 1'b0;
      case (state_q)
        dbg_pkg::IDLE: if (rx_valid_i) begin
          cmd_q      <= rx_data_i;
          byte_cnt_q <= '0;
          if (rx_data_i == `DBG_BYTE_ACK) begin
            state_q <= dbg_pkg::SEND_ACK;
          end else if (rx_data_i inside {`DBG_CMD_READ, `DBG_CMD_WRITE, `DBG_CMD_EXEC}) begin
            state_q <= dbg_pkg::GET_ADDR;
          end
          // Anything else is noise on the line
        end
        // Eight address bytes, little endian
        dbg_pkg::GET_ADDR: if (rx_valid_i) begin
          byte_cnt_q <= byte_cnt_q + 3'd1;
          if (last_byte) begin
            if (cmd_q == `DBG_CMD_EXEC) begin
              exec_o  <= 1'b1;
              state_q <= dbg_pkg::SEND_ACK;
            end else begin
              state_q <= dbg_pkg::GET_LEN;
            end
          end
        end
        // Eight length bytes, only the low two are kept
        dbg_pkg::GET_LEN: if (rx_valid_i) begin
          byte_cnt_q <= byte_cnt_q + 3'd1;
          if (byte_cnt_q == 3'd0) len_q[7:0] <= rx_data_i;
          if (byte_cnt_q == 3'd1) len_q[15:8] <= rx_data_i;
          if (last_byte) begin
            off_q   <= '0;
            state_q <= dbg_pkg::SEND_ACK;
          end
        end
        dbg_pkg::SEND_ACK: if (tx_ready) begin
          tx_start_o <= 1'b1;
          if (cmd_q == `DBG_CMD_READ) begin
            state_q <= len_zero ? dbg_pkg::SEND_EOT : dbg_pkg::RD_DATA;
          end else if (cmd_q == `DBG_CMD_WRITE) begin
            state_q <= len_zero ? dbg_pkg::SEND_EOT : dbg_pkg::WR_DATA;
          end else begin
            state_q <= dbg_pkg::IDLE;
          end
        end
        // One byte per frame, next read lands long before the frame ends
        dbg_pkg::RD_DATA: if (tx_ready) begin
          tx_start_o <= 1'b1;
          off_q      <= off_q + 16'd1;
          if (last_data) state_q <= dbg_pkg::SEND_EOT;
        end
        dbg_pkg::WR_DATA: if (rx_valid_i) begin
          off_q <= off_q + 16'd1;
          if (last_data) state_q <= dbg_pkg::SEND_EOT;
        end
        dbg_pkg::SEND_EOT: if (tx_ready) begin
          tx_start_o <= 1'b1;
          state_q    <= dbg_pkg::IDLE;
        end
        default: state_q <= dbg_pkg::IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Address, reply byte and read port
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state_q == dbg_pkg::GET_ADDR && rx_valid_i) begin
      addr_q <= {rx_data_i, addr_q[63:8]};
    end
    // Reply byte follows the state that will issue the start
    if (tx_ready) begin
      if (state_q == dbg_pkg::RD_DATA) begin
        tx_data_o <= rd_data_q;
      end else if (state_q == dbg_pkg::SEND_EOT) begin
        tx_data_o <= `DBG_BYTE_EOT;
      end else begin
        tx_data_o <= `DBG_BYTE_ACK;
      end
    end
    rd_data_q <= mem_q[mem_idx];
  end

  // Target memory, cleared on reset
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < MemDepth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (mem_we) begin
      mem_q[mem_idx] <= rx_data_i;
    end
  end

endmodule

// File: verilog/uart_dbg_top.sv
// UART debug target top level

`timescale 1ns/1ps

module uart_dbg_top (
  input  logic        clk,
  input  logic        arst_n_i,
  input  logic        uart_rx_i,
  output logic        uart_tx_o,
  output logic        exec_o,
  output logic [63:0] exec_addr_o,
  output logic        perr_o
);

  dbg_pkg::dbg_byte_t rx_data;
  logic               rx_valid;
  dbg_pkg::dbg_byte_t tx_data;
  logic               tx_start;
  logic               tx_busy;

  // Parity errors go straight out as a flag
  uart_rx u_uart_rx (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .rxd_i      ( uart_rx_i ),
    .rx_data_o  ( rx_data   ),
    .rx_valid_o ( rx_valid  ),
    .rx_perr_o  ( perr_o    )
  );

  dbg_server u_dbg_server (
    .clk         ( clk         ),
    .arst_n_i    ( arst_n_i    ),
    .rx_data_i   ( rx_data     ),
    .rx_valid_i  ( rx_valid    ),
    .tx_busy_i   ( tx_busy     ),
    .tx_data_o   ( tx_data     ),
    .tx_start_o  ( tx_start    ),
    .exec_o      ( exec_o      ),
    .exec_addr_o ( exec_addr_o )
  );

  uart_tx u_uart_tx (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .tx_data_i  ( tx_data   ),
    .tx_start_i ( tx_start  ),
    .txd_o      ( uart_tx_o ),
    .tx_busy_o  ( tx_busy   )
  );

endmodule

// File: sim/tb_uart_dbg.sv
// UART debug target testbench

`timescale 1ns/1ps
`include "dbg_settings.svh"

module tb_uart_dbg;

  localparam int Cpb         = `DBG_CLKS_PER_BIT;
  localparam int FrameBits   = 10 + `DBG_PARITY_EN;
  localparam int ReplyWait   = 1000;
  localparam int QuietCycles = 600;

  logic        clk;
  logic        arst_n_i;
  logic        uart_rx_i;
  logic        uart_tx_o;
  logic        exec_o;
  logic [63:0] exec_addr_o;
  logic        perr_o;

  logic [31:0]        rng;
  int                 err_cnt;
  int                 tmo_cnt;
  int                 exec_cnt;
  int                 perr_cnt;
  logic [63:0]        exec_addr_seen;
  int                 bad_idx;
  dbg_pkg::dbg_byte_t mem_model [256];
  dbg_pkg::dbg_byte_t req_q [$];
  dbg_pkg::dbg_byte_t rsp_q [$];

  uart_dbg_top u_uart_dbg_top (
    .clk         ( clk         ),
    .arst_n_i    ( arst_n_i    ),
    .uart_rx_i   ( uart_rx_i   ),
    .uart_tx_o   ( uart_tx_o   ),
    .exec_o      ( exec_o      ),
    .exec_addr_o ( exec_addr_o ),
    .perr_o      ( perr_o      )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Count output pulses on the falling edge where they have settled
  always @(negedge clk) begin
    if (exec_o === 1'b1) begin
      exec_cnt++;
      exec_addr_seen = exec_addr_o;
    end
    if (perr_o === 1'b1) perr_cnt++;
  end

  //////////////////////////////////////////////////
  // Random numbers and compare tasks
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  task automatic check_byte(input string name, input dbg_pkg::dbg_byte_t got,
                            input dbg_pkg::dbg_byte_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %s got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %s got 0x%016h expected 0x%016h", name, got, exp);
    end
  endtask

  task automatic check_pulse_count(input string name, input int got, input int exp);
    if (got != exp) begin
      err_cnt++;
      $display("FAIL %s pulse count got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Host side of the UART link
  //////////////////////////////////////////////////

  // Start bit, data LSB first, parity bit and stop bit
  task automatic send_frame(input dbg_pkg::dbg_byte_t b, input logic bad_par);
    logic [10:0] bits;
    bits = {1'b1, ^b ^ bad_par, b, 1'b0};
    if (`DBG_PARITY_EN == 0) bits = {2'b11, b, 1'b0};
    @(negedge clk);
    for (int i = 0; i < FrameBits; i++) begin
      uart_rx_i = bits[i];
      repeat (Cpb) @(negedge clk);
    end
  endtask

  task automatic recv_frame(output dbg_pkg::dbg_byte_t b, output logic ok);
    int                  n;
    logic                par;
    dbg_pkg::dbg_state_e st;
    b  = '0;
    ok = 1'b0;
    n  = 0;
    while (uart_tx_o !== 1'b0 && n < ReplyWait) begin
      @(negedge clk);
      n++;
    end
    if (uart_tx_o !== 1'b0) begin
      tmo_cnt++;
      st = u_uart_dbg_top.u_dbg_server.state_q;
      $display("Timeout: no reply frame within %0d cycles, server in %s", ReplyWait, st.name());
      return;
    end
    // Middle of the start bit
    repeat (Cpb / 2 - 1) @(negedge clk);
    if (uart_tx_o !== 1'b0) begin
      err_cnt++;
      $display("Start bit on uart_tx_o ended before its middle");
      return;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (Cpb) @(negedge clk);
      b[i] = uart_tx_o;
    end
    if (`DBG_PARITY_EN != 0) begin
      repeat (Cpb) @(negedge clk);
      par = uart_tx_o;
      if (par !== ^b) begin
        err_cnt++;
        $display("Reply frame on uart_tx_o has odd parity");
      end
    end
    repeat (Cpb) @(negedge clk);
    if (uart_tx_o !== 1'b1) begin
      err_cnt++;
      $display("Reply frame on uart_tx_o has no stop bit");
    end
    ok = 1'b1;
  endtask

  task automatic expect_silence(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      if (uart_tx_o !== 1'b1) begin
        err_cnt++;
        $display("Frame on uart_tx_o where no reply was due");
        return;
      end
    end
  endtask

  // Every queued reply and then a quiet line
  task automatic expect_replies();
    dbg_pkg::dbg_byte_t b;
    logic               ok;
    for (int i = 0; i < rsp_q.size(); i++) begin
      recv_frame(b, ok);
      if (!ok) return;
      check_byte("uart_tx_o", b, rsp_q[i]);
    end
    expect_silence(QuietCycles);
  endtask

  // Reply may start inside the stop bit of the last request byte
  task automatic exchange();
    for (int i = 0; i < req_q.size() - 1; i++) begin
      send_frame(req_q[i], i == bad_idx);
    end
    fork
      send_frame(req_q[req_q.size() - 1], (req_q.size() - 1) == bad_idx);
      expect_replies();
    join
    req_q.delete();
    rsp_q.delete();
    bad_idx = -1;
  endtask

  //////////////////////////////////////////////////
  // Debug commands
  //////////////////////////////////////////////////

  task automatic push_header(input dbg_pkg::dbg_byte_t cmd, input logic [63:0] addr,
                             input int len);
    req_q.push_back(cmd);
    for (int i = 0; i < 8; i++) begin
      req_q.push_back(addr[8*i +: 8]);
    end
    if (cmd != `DBG_CMD_EXEC) begin
      for (int i = 0; i < 8; i++) begin
        req_q.push_back(i < 4 ? 8'(len >> (8 * i)) : 8'h00);
      end
    end
  endtask

  task automatic do_write(input logic [63:0] addr, input int len, input int bad_pos);
    dbg_pkg::dbg_byte_t d;
    logic [7:0]         idx;
    push_header(`DBG_CMD_WRITE, addr, len);
    rsp_q.push_back(`DBG_BYTE_ACK);
    if (len == 0) rsp_q.push_back(`DBG_BYTE_EOT);
    exchange();
    if (len == 0) return;
    for (int j = 0; j < len; j++) begin
      // Corrupted byte never reaches the memory
      if (j == bad_pos) begin
        bad_idx = req_q.size();
        req_q.push_back(8'(next_rand()));
      end
      d = 8'(next_rand());
      idx = addr[7:0] + 8'(j);
      mem_model[idx] = d;
      req_q.push_back(d);
    end
    rsp_q.push_back(`DBG_BYTE_EOT);
    exchange();
  endtask

  task automatic do_read(input logic [63:0] addr, input int len);
    logic [7:0] idx;
    push_header(`DBG_CMD_READ, addr, len);
    rsp_q.push_back(`DBG_BYTE_ACK);
    for (int j = 0; j < len; j++) begin
      idx = addr[7:0] + 8'(j);
      rsp_q.push_back(mem_model[idx]);
    end
    rsp_q.push_back(`DBG_BYTE_EOT);
    exchange();
  endtask

  task automatic do_exec(input logic [63:0] addr);
    int base;
    base = exec_cnt;
    push_header(`DBG_CMD_EXEC, addr, 0);
    rsp_q.push_back(`DBG_BYTE_ACK);
    exchange();
    check_pulse_count("exec_o", exec_cnt - base, 1);
    check_addr("exec_addr_o", exec_addr_seen, addr);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [63:0]        addr;
    int                 len;
    int                 base;
    dbg_pkg::dbg_byte_t b;
    arst_n_i  = 1'b0;
    uart_rx_i = 1'b1;
    rng       = 32'h7cfc;
    err_cnt   = 0;
    tmo_cnt   = 0;
    exec_cnt  = 0;
    perr_cnt  = 0;
    bad_idx   = -1;
    for (int i = 0; i < 256; i++) begin
      mem_model[i] = '0;
    end
    repeat (16) @(negedge clk);
    arst_n_i = 1'b1;

    // Quiet line after reset and then the ACK challenge
    expect_silence(200);
    check_pulse_count("exec_o", exec_cnt, 0);
    check_pulse_count("perr_o", perr_cnt, 0);
    req_q.push_back(`DBG_BYTE_ACK);
    rsp_q.push_back(`DBG_BYTE_ACK);
    exchange();

    // Untouched memory reads as zero
    do_read(64'h40, 16);
    do_read({next_rand(), next_rand()}, 0);

    // Every fourth block sits at the top of memory and wraps
    for (int k = 0; k < 20; k++) begin
      addr = {next_rand(), next_rand()};
      if (k % 4 == 0) addr[7:0] = 8'hf8 | (addr[7:0] & 8'h07);
      len = 1 + int'(next_rand() & 32'hf);
      if (k % 4 == 0) len = 9 + (len & 7);
      do_write(addr, len, -1);
      do_read(addr, len);
    end

    for (int k = 0; k < 4; k++) begin
      do_exec({next_rand(), next_rand()});
    end

    // Bad parity on the challenge gets no answer
    base = perr_cnt;
    req_q.push_back(`DBG_BYTE_ACK);
    bad_idx = 0;
    exchange();
    check_pulse_count("perr_o", perr_cnt - base, 1);
    base = perr_cnt;
    addr = {next_rand(), next_rand()};
    do_write(addr, 6, 2);
    check_pulse_count("perr_o", perr_cnt - base, 1);
    do_read(addr, 6);

    // Noise in idle
    for (int k = 0; k < 8; k++) begin
      b = 8'(next_rand());
      if (b inside {`DBG_BYTE_ACK, `DBG_CMD_READ, `DBG_CMD_WRITE, `DBG_CMD_EXEC}) b = 8'h55;
      req_q.push_back(b);
      exchange();
    end
    req_q.push_back(`DBG_BYTE_ACK);
    rsp_q.push_back(`DBG_BYTE_ACK);
    exchange();

    $display("Error counts: %0d wrong value, %0d timeout", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+verilog
verilog/dbg_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/dbg_server.sv
verilog/uart_dbg_top.sv
sim/tb_uart_dbg.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the UART debug target simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f project.f --top-module tb_uart_dbg -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_uart_dbg" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
